// ==== Makefile ====
# Verilator build and run of the front-panel testbench

VERILATOR ?= verilator
TOP       ?= tb_panel
FILELIST  ?= panel.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= test passed

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	@out=$$(./$(BUILD_DIR)/V$(TOP)); echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== common/key_event_if.sv ====
`timescale 1ns/1ps
`default_nettype none

// one-cycle key events, at most one high per cycle
interface key_event_if;

    logic left;
    logic right;
    logic up;
    logic down;
    logic confirm;
    logic quit;
    logic oscup;

    modport src (output left, right, up, down, confirm, quit, oscup);
    modport dst (input left, right, up, down, confirm, quit, oscup);

endinterface

`default_nettype wire

// ==== common/panel_pkg.sv ====
`default_nettype none

package panel_pkg;

    localparam int N_KEYS = 7;
    localparam int KEY_LEFT = 0;
    localparam int KEY_RIGHT = 1;
    localparam int KEY_UP = 2;
    localparam int KEY_DOWN = 3;
    localparam int KEY_CONFIRM = 4;
    localparam int KEY_QUIT = 5;
    localparam int KEY_OSCUP = 6;

    localparam int DEBOUNCE_CYCLES = 1000;    // stable cycles before a level is taken
    localparam int MENU_ITEMS = 3;
    localparam int SIG_ROWS = 5;              // rows 0..3 fields, row 4 run
    localparam int FIELD_MAX = 3;
    localparam int ZOOM_MAX = 2;
    localparam int RATE_MAX = 14;
    localparam int LA_DIV_DEFAULT = 9;
    localparam int OSC_RATE_DEFAULT = 14;
    localparam int MARKER_STEP = 80;
    localparam int MARKER_MAX = 1440;
    localparam int LA_VIEWS = 3;

    typedef enum logic [1:0] {TOP, SIG, OSC, LA} mode_t;

    // step a selector over 0..top, wrapping at both ends
    function automatic logic [3:0] wrap_step(input logic [3:0] val, input logic [3:0] top,
                                             input logic inc, input logic dec);
        logic [3:0] res;
        res = val;
        if (inc) begin
            res = (val == top) ? 4'd0 : val + 4'd1;
        end else if (dec) begin
            res = (val == 4'd0) ? top : val - 4'd1;
        end
        return res;
    endfunction

endpackage

`default_nettype wire

// ==== design/instrument_settings.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrument_settings (
    input  wire              clk_50M,
    input  wire              rst_n,
    key_event_if.dst         ev,
    input  panel_pkg::mode_t mode,
    input  wire [1:0]        menu_sel,
    output logic [2:0]       sig_row,
    output logic [1:0]       sig_wave,
    output logic [1:0]       sig_amp,
    output logic [1:0]       sig_freq,
    output logic [1:0]       sig_phase,
    output logic             sig_run,
    output logic             fft_on,
    output logic [1:0]       v_zoom,
    output logic [1:0]       h_zoom,
    output logic [3:0]       osc_rate,
    output logic             la_active,
    output logic [10:0]      la_marker,
    output logic [1:0]       la_view,
    output logic [3:0]       la_div
);

    localparam logic [3:0] FMAX = 4'(panel_pkg::FIELD_MAX);
    localparam logic [3:0] ZMAX = 4'(panel_pkg::ZOOM_MAX);
    localparam logic [3:0] RMAX = 4'(panel_pkg::RATE_MAX);
    localparam logic [10:0] MSTEP = 11'(panel_pkg::MARKER_STEP);
    localparam logic [10:0] MMAX = 11'(panel_pkg::MARKER_MAX);

    logic in_sig;
    logic in_osc;
    logic in_la;

    assign in_sig = (mode == panel_pkg::SIG);
    assign in_osc = (mode == panel_pkg::OSC);
    assign in_la = (mode == panel_pkg::LA);

    always_ff @(posedge clk_50M) begin
        if (!rst_n || !in_sig) begin
            sig_row <= 3'd0;
            sig_wave <= 2'd0;
            sig_amp <= 2'd0;
            sig_freq <= 2'd0;
            sig_phase <= 2'd0;
            sig_run <= 1'b0;
        end else begin
            sig_row <= 3'(panel_pkg::wrap_step(4'(sig_row), 4'(panel_pkg::SIG_ROWS - 1),
                                               ev.down, ev.up));
            case (sig_row)    // row picks the field
                3'd0: sig_wave <= 2'(panel_pkg::wrap_step(4'(sig_wave), FMAX, ev.right, ev.left));
                3'd1: sig_amp <= 2'(panel_pkg::wrap_step(4'(sig_amp), FMAX, ev.right, ev.left));
                3'd2: sig_freq <= 2'(panel_pkg::wrap_step(4'(sig_freq), FMAX, ev.right, ev.left));
                3'd3: sig_phase <= 2'(panel_pkg::wrap_step(4'(sig_phase), FMAX, ev.right, ev.left));
                default: ;
            endcase
            if (ev.confirm && sig_row == 3'(panel_pkg::SIG_ROWS - 1)) begin
                sig_run <= 1'b1;
            end else if (ev.quit) begin
                sig_run <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            fft_on <= 1'b0;
            v_zoom <= 2'd0;
            h_zoom <= 2'd0;
            osc_rate <= 4'(panel_pkg::OSC_RATE_DEFAULT);
        end else begin
            fft_on <= in_osc && (fft_on || ev.confirm);
            if (in_osc && !fft_on) begin
                v_zoom <= 2'(panel_pkg::wrap_step(4'(v_zoom), ZMAX, ev.up, ev.down));
                h_zoom <= 2'(panel_pkg::wrap_step(4'(h_zoom), ZMAX, ev.right, ev.left));
            end else begin
                v_zoom <= 2'd0;    // zoom frozen at 0 in FFT view
                h_zoom <= 2'd0;
            end
            if (menu_sel == 2'd1) begin
                osc_rate <= panel_pkg::wrap_step(osc_rate, RMAX, ev.oscup, 1'b0);
            end else begin
                osc_rate <= 4'(panel_pkg::OSC_RATE_DEFAULT);
            end
        end
    end

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            la_active <= 1'b0;
            la_marker <= MSTEP;
            la_view <= 2'd0;
            la_div <= 4'(panel_pkg::LA_DIV_DEFAULT);
        end else begin
            la_active <= in_la;
            if (!in_la) begin
                la_marker <= MSTEP;
            end else if (ev.left) begin
                la_marker <= (la_marker == MSTEP) ? MMAX : la_marker - MSTEP;
            end else if (ev.right) begin
                la_marker <= (la_marker == MMAX) ? MSTEP : la_marker + MSTEP;
            end
            if (menu_sel != 2'd2) begin
                la_view <= 2'd0;
                la_div <= 4'(panel_pkg::LA_DIV_DEFAULT);
            end else if (mode == panel_pkg::TOP) begin
                la_view <= 2'(panel_pkg::wrap_step(4'(la_view), 4'(panel_pkg::LA_VIEWS - 1),
                                                   ev.up, 1'b0));
                la_div <= panel_pkg::wrap_step(la_div, RMAX, ev.down, 1'b0);
            end else if (in_la && la_view == 2'd1) begin
                la_div <= panel_pkg::wrap_step(la_div, RMAX, ev.up, ev.down);    // view holds
            end
        end
    end

    a_marker_grid: assert property (@(posedge clk_50M) disable iff (!rst_n)
        (la_marker % MSTEP == 11'd0) && la_marker >= MSTEP && la_marker <= MMAX)
        else $error("la_marker off grid: %0d", la_marker);

endmodule

`default_nettype wire

// ==== design/menu_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module menu_fsm (
    input  wire              clk_50M,
    input  wire              rst_n,
    key_event_if.dst         ev,
    output panel_pkg::mode_t mode,
    output logic [1:0]       menu_sel
);

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            mode <= panel_pkg::TOP;
            menu_sel <= 2'd0;
        end else begin
            case (mode)
                panel_pkg::TOP: begin
                    menu_sel <= 2'(panel_pkg::wrap_step(4'(menu_sel),
                                                        4'(panel_pkg::MENU_ITEMS - 1),
                                                        ev.right, ev.left));
                    if (ev.confirm) begin
                        case (menu_sel)
                            2'd0: mode <= panel_pkg::SIG;
                            2'd1: mode <= panel_pkg::OSC;
                            default: mode <= panel_pkg::LA;
                        endcase
                    end
                end
                default: begin
                    // every instrument leaves on quit
                    if (ev.quit) begin
                        mode <= panel_pkg::TOP;
                        menu_sel <= 2'd0;
                    end
                end
            endcase
        end
    end

    a_sel_range: assert property (@(posedge clk_50M) disable iff (!rst_n)
        menu_sel != 2'd3)
        else $error("menu_sel out of range");

    // an instrument mode always matches the item that entered it
    a_mode_sel: assert property (@(posedge clk_50M) disable iff (!rst_n)
        mode != panel_pkg::TOP |-> menu_sel == 2'(mode) - 2'd1)
        else $error("mode and menu_sel disagree");

endmodule

`default_nettype wire

// ==== design/panel_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module panel_top (
    input  wire                         clk_50M,
    input  wire                         rst_n,
    input  wire [panel_pkg::N_KEYS-1:0] key_in,
    output logic [1:0]                  mode,
    output logic [1:0]                  menu_sel,
    output logic [2:0]                  sig_row,
    output logic [1:0]                  sig_wave,
    output logic [1:0]                  sig_amp,
    output logic [1:0]                  sig_freq,
    output logic [1:0]                  sig_phase,
    output logic                        sig_run,
    output logic                        fft_on,
    output logic [1:0]                  v_zoom,
    output logic [1:0]                  h_zoom,
    output logic [3:0]                  osc_rate,
    output logic                        la_active,
    output logic [10:0]                 la_marker,
    output logic [1:0]                  la_view,
    output logic [3:0]                  la_div,
    output logic [3:0]                  clkmode
);

    logic [panel_pkg::N_KEYS-1:0] key_level;
    logic [panel_pkg::N_KEYS-1:0] releases;
    panel_pkg::mode_t             mode_st;

    key_event_if key_ev ();

    key_sync key_sync_inst (
        .clk_50M (clk_50M),
        .rst_n   (rst_n),
        .raw     (key_in),
        .level   (key_level)
    );

    // one debouncer per key
    for (genvar i = 0; i < panel_pkg::N_KEYS; i++) begin : g_deb
        key_debounce key_debounce_inst (
            .clk_50M       (clk_50M),
            .rst_n         (rst_n),
            .level         (key_level[i]),
            .release_pulse (releases[i])
        );
    end

    key_arbiter key_arbiter_inst (
        .clk_50M  (clk_50M),
        .rst_n    (rst_n),
        .releases (releases),
        .ev       (key_ev.src)
    );

    menu_fsm menu_fsm_inst (
        .clk_50M  (clk_50M),
        .rst_n    (rst_n),
        .ev       (key_ev.dst),
        .mode     (mode_st),
        .menu_sel (menu_sel)
    );

    instrument_settings instrument_settings_inst (
        .clk_50M   (clk_50M),
        .rst_n     (rst_n),
        .ev        (key_ev.dst),
        .mode      (mode_st),
        .menu_sel  (menu_sel),
        .sig_row   (sig_row),
        .sig_wave  (sig_wave),
        .sig_amp   (sig_amp),
        .sig_freq  (sig_freq),
        .sig_phase (sig_phase),
        .sig_run   (sig_run),
        .fft_on    (fft_on),
        .v_zoom    (v_zoom),
        .h_zoom    (h_zoom),
        .osc_rate  (osc_rate),
        .la_active (la_active),
        .la_marker (la_marker),
        .la_view   (la_view),
        .la_div    (la_div)
    );

    assign mode = mode_st;

    always_comb begin
        case (menu_sel)
            2'd1: clkmode = osc_rate;    // scope sample clock
            2'd2: clkmode = la_div;      // analyzer divider
            default: clkmode = 4'd0;
        endcase
    end

endmodule

`default_nettype wire

// ==== keys/key_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_arbiter (
    input  wire                         clk_50M,
    input  wire                         rst_n,
    input  wire [panel_pkg::N_KEYS-1:0] releases,
    key_event_if.src                    ev
);

    logic [panel_pkg::N_KEYS-1:0] lowest;
    logic [panel_pkg::N_KEYS-1:0] ev_q;

    assign lowest = releases & (~releases + 1'b1);    // keep lowest set bit

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            ev_q <= '0;
        end else begin
            ev_q <= lowest;
        end
    end

    assign ev.left = ev_q[panel_pkg::KEY_LEFT];
    assign ev.right = ev_q[panel_pkg::KEY_RIGHT];
    assign ev.up = ev_q[panel_pkg::KEY_UP];
    assign ev.down = ev_q[panel_pkg::KEY_DOWN];
    assign ev.confirm = ev_q[panel_pkg::KEY_CONFIRM];
    assign ev.quit = ev_q[panel_pkg::KEY_QUIT];
    assign ev.oscup = ev_q[panel_pkg::KEY_OSCUP];

    a_one_event: assert property (@(posedge clk_50M) disable iff (!rst_n)
        $onehot0({ev.oscup, ev.quit, ev.confirm, ev.down, ev.up, ev.right, ev.left}))
        else $error("more than one key event in a cycle");

endmodule

`default_nettype wire

// ==== keys/key_debounce.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_debounce (
    input  wire  clk_50M,
    input  wire  rst_n,
    input  wire  level,
    output logic release_pulse
);

    logic stable;
    logic [$clog2(panel_pkg::DEBOUNCE_CYCLES)-1:0] cnt;

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            stable <= 1'b0;
            cnt <= '0;
            release_pulse <= 1'b0;
        end else begin
            release_pulse <= 1'b0;
            if (level == stable) begin
                cnt <= '0;    // input agrees, restart
            end else if (cnt == $bits(cnt)'(panel_pkg::DEBOUNCE_CYCLES - 1)) begin
                cnt <= '0;
                stable <= level;
                // a change away from 1 is a key release
                release_pulse <= stable;
            end else begin
                cnt <= cnt + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== keys/key_sync.sv ====
`timescale 1ns/1ps
`default_nettype none

module key_sync (
    input  wire                          clk_50M,
    input  wire                          rst_n,
    input  wire [panel_pkg::N_KEYS-1:0]  raw,
    output logic [panel_pkg::N_KEYS-1:0] level
);

    logic [panel_pkg::N_KEYS-1:0] meta;    // first stage, may go metastable

    always_ff @(posedge clk_50M) begin
        if (!rst_n) begin
            meta <= '0;
            level <= '0;
        end else begin
            meta <= raw;
            level <= meta;
        end
    end

endmodule

`default_nettype wire

// ==== panel.f ====
common/panel_pkg.sv
common/key_event_if.sv
keys/key_sync.sv
keys/key_debounce.sv
keys/key_arbiter.sv
design/menu_fsm.sv
design/instrument_settings.sv
design/panel_top.sv
test/tb_panel.sv

// ==== test/tb_panel.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_panel;

    localparam int PRESSES = 60;
    localparam int HOLD = 1500;
    localparam int GLITCH = 200;
    localparam int LIMIT = PRESSES * 2 * HOLD + 10000;

    logic        clk_50M;
    logic        rst_n;
    logic [6:0]  key_in;
    logic [1:0]  mode;
    logic [1:0]  menu_sel;
    logic [2:0]  sig_row;
    logic [1:0]  sig_wave;
    logic [1:0]  sig_amp;
    logic [1:0]  sig_freq;
    logic [1:0]  sig_phase;
    logic        sig_run;
    logic        fft_on;
    logic [1:0]  v_zoom;
    logic [1:0]  h_zoom;
    logic [3:0]  osc_rate;
    logic        la_active;
    logic [10:0] la_marker;
    logic [1:0]  la_view;
    logic [3:0]  la_div;
    logic [3:0]  clkmode;

    int errors = 0;
    int cycles = 0;
    logic [31:0] rnd;

    // reference model state
    int m_mode;
    int m_sel;
    int m_row;
    int m_run;
    int m_fft;
    int m_vz;
    int m_hz;
    int m_rate;
    int m_marker;
    int m_view;
    int m_div;
    int m_field [4];    // wave, amp, freq, phase

    panel_top panel_top_inst (
        .clk_50M   (clk_50M),
        .rst_n     (rst_n),
        .key_in    (key_in),
        .mode      (mode),
        .menu_sel  (menu_sel),
        .sig_row   (sig_row),
        .sig_wave  (sig_wave),
        .sig_amp   (sig_amp),
        .sig_freq  (sig_freq),
        .sig_phase (sig_phase),
        .sig_run   (sig_run),
        .fft_on    (fft_on),
        .v_zoom    (v_zoom),
        .h_zoom    (h_zoom),
        .osc_rate  (osc_rate),
        .la_active (la_active),
        .la_marker (la_marker),
        .la_view   (la_view),
        .la_div    (la_div),
        .clkmode   (clkmode)
    );

    initial clk_50M = 1'b0;
    always #10 clk_50M = ~clk_50M;

    always @(posedge clk_50M) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("timeout: no end of test after %0d cycles", LIMIT);
            $display("test failed");
            $finish;
        end
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic int step_up(input int v, input int top);
        return (v >= top) ? 0 : v + 1;
    endfunction

    function automatic int step_down(input int v, input int top);
        return (v == 0) ? top : v - 1;
    endfunction

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_50M);
        #1;    // drive and sample just after the edge
    endtask

    task automatic reset_model();
        m_mode = 0;
        m_sel = 0;
        m_row = 0;
        m_run = 0;
        m_fft = 0;
        m_vz = 0;
        m_hz = 0;
        m_rate = 14;
        m_marker = 80;
        m_view = 0;
        m_div = 9;
        foreach (m_field[i]) m_field[i] = 0;
    endtask

    // k runs from 0 left to 6 oscup in key order
    task automatic apply_key(input int k);
        int old_mode;
        int old_sel;
        int old_row;
        old_mode = m_mode;
        old_sel = m_sel;
        old_row = m_row;
        if (old_mode == 0) begin
            if (k == 0) m_sel = step_down(old_sel, 2);
            if (k == 1) m_sel = step_up(old_sel, 2);
            if (k == 4) m_mode = old_sel + 1;
        end else if (k == 5) begin
            m_mode = 0;
            m_sel = 0;
        end
        if (old_mode == 1) begin
            if (k == 3) m_row = step_up(old_row, 4);
            if (k == 2) m_row = step_down(old_row, 4);
            if (old_row < 4 && k == 1) m_field[old_row] = step_up(m_field[old_row], 3);
            if (old_row < 4 && k == 0) m_field[old_row] = step_down(m_field[old_row], 3);
            if (k == 4 && old_row == 4) m_run = 1;
            else if (k == 5) m_run = 0;
        end
        if (old_mode == 2 && m_fft == 0) begin
            if (k == 2) m_vz = step_up(m_vz, 2);
            if (k == 3) m_vz = step_down(m_vz, 2);
            if (k == 1) m_hz = step_up(m_hz, 2);
            if (k == 0) m_hz = step_down(m_hz, 2);
        end
        if (old_mode == 2 && k == 4) m_fft = 1;
        if (old_sel == 1 && k == 6) m_rate = step_up(m_rate, 14);
        if (old_mode == 3 && k == 0) m_marker = (m_marker == 80) ? 1440 : m_marker - 80;
        if (old_mode == 3 && k == 1) m_marker = (m_marker == 1440) ? 80 : m_marker + 80;
        if (old_sel == 2 && old_mode == 0) begin
            if (k == 2) m_view = step_up(m_view, 2);
            if (k == 3) m_div = step_up(m_div, 14);
        end else if (old_sel == 2 && old_mode == 3 && m_view == 1) begin
            if (k == 2) m_div = step_up(m_div, 14);
            if (k == 3) m_div = step_down(m_div, 14);
        end
        // settle in the new mode
        if (m_mode != 1) begin
            m_row = 0;
            m_run = 0;
            foreach (m_field[i]) m_field[i] = 0;
        end
        if (m_mode != 2) m_fft = 0;
        if (m_mode != 2 || m_fft == 1) begin
            m_vz = 0;
            m_hz = 0;
        end
        if (m_sel != 1) m_rate = 14;
        if (m_mode != 3) m_marker = 80;
        if (m_sel != 2) begin
            m_view = 0;
            m_div = 9;
        end
    endtask

    task automatic check_val(input string name, input logic [31:0] got, input int exp);
        assert (got == exp) else begin
            errors++;
            $display("[ERROR] %0t %s: got %0d, expected %0d", $time, name, got, exp);
        end
    endtask

    task automatic check_all();
        check_val("mode", mode, m_mode);
        check_val("menu_sel", menu_sel, m_sel);
        check_val("sig_row", sig_row, m_row);
        check_val("sig_wave", sig_wave, m_field[0]);
        check_val("sig_amp", sig_amp, m_field[1]);
        check_val("sig_freq", sig_freq, m_field[2]);
        check_val("sig_phase", sig_phase, m_field[3]);
        check_val("sig_run", sig_run, m_run);
        check_val("fft_on", fft_on, m_fft);
        check_val("v_zoom", v_zoom, m_vz);
        check_val("h_zoom", h_zoom, m_hz);
        check_val("osc_rate", osc_rate, m_rate);
        check_val("la_active", la_active, (m_mode == 3) ? 1 : 0);
        check_val("la_marker", la_marker, m_marker);
        check_val("la_view", la_view, m_view);
        check_val("la_div", la_div, m_div);
        check_val("clkmode", clkmode, (m_sel == 1) ? m_rate : (m_sel == 2) ? m_div : 0);
    endtask

    task automatic press_key(input int k);
        key_in[k] = 1'b1;
        wait_cycles(HOLD);
        key_in[k] = 1'b0;
        wait_cycles(HOLD);
        apply_key(k);
        check_all();
    endtask

    // shorter than the debounce time so nothing changes
    task automatic inject_glitch(input int k);
        key_in[k] = 1'b1;
        wait_cycles(GLITCH);
        key_in[k] = 1'b0;
        wait_cycles(HOLD - GLITCH);
        check_all();
    endtask

    initial begin
        rst_n = 1'b0;
        key_in = '0;
        rnd = 32'd36146;
        reset_model();
        repeat (3) @(posedge clk_50M);
        #1;
        rst_n = 1'b1;
        check_all();
        for (int i = 0; i < PRESSES; i++) begin
            rnd = xorshift(rnd);
            if (i == 20 || i == 40) begin
                inject_glitch(int'(rnd % 7));
                rnd = xorshift(rnd);
            end
            press_key(int'(rnd % 7));
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
